//--- logic/fp_adder.sv
`timescale 1ns/1ps

module fp_adder (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           enable,
    input  logic           sub,
    input  fpu_pkg::fp32_t a,
    input  fpu_pkg::fp32_t b,
    output fpu_pkg::fp32_t y
);

    // stage one signals
    logic        a_zero;
    logic        b_zero;
    logic        b_sign;      // sign of b after the subtract flip
    logic [30:0] a_mag;
    logic [30:0] b_mag;
    logic        hi_sign;
    logic [7:0]  hi_exp;
    logic [7:0]  lo_exp;
    logic [25:0] hi_sig;
    logic [25:0] lo_sig;
    logic [7:0]  shamt;
    logic [25:0] lo_aligned;

    logic        s1_sign;
    logic        s1_eff_sub;
    logic        s1_neg_zero;
    logic [7:0]  s1_exp;
    logic [25:0] s1_hi_sig;
    logic [25:0] s1_lo_sig;

    // stage two signals
    logic [26:0]       sum;
    logic [4:0]        lz;
    logic [25:0]       norm_sig;
    logic signed [9:0] exp_n;
    fpu_pkg::fp32_t    res;

    function automatic logic [4:0] count_lz(input logic [25:0] v);
        logic [4:0] n;
        logic       found;
        n     = 5'd0;
        found = 1'b0;
        for (int i = 25; i >= 0; i--) begin
            if (v[i])
                found = 1'b1;
            if (!found)
                n = n + 5'd1;
        end
        return n;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage one: flush, order by magnitude, align
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        a_zero = (a.fields.exponent == 8'd0);  // subnormals count as zero
        b_zero = (b.fields.exponent == 8'd0);
        b_sign = b.fields.sign ^ sub;
        a_mag  = a_zero ? 31'd0 : a.raw[30:0];
        b_mag  = b_zero ? 31'd0 : b.raw[30:0];

        if (b_mag > a_mag) begin
            hi_sign = b_sign;
            hi_exp  = b.fields.exponent;
            lo_exp  = a.fields.exponent;
            hi_sig  = {1'b1, b.fields.mantissa, 2'b00};
            lo_sig  = a_zero ? 26'd0 : {1'b1, a.fields.mantissa, 2'b00};
        end else begin
            hi_sign = a.fields.sign;
            hi_exp  = a.fields.exponent;
            lo_exp  = b.fields.exponent;
            hi_sig  = a_zero ? 26'd0 : {1'b1, a.fields.mantissa, 2'b00};
            lo_sig  = b_zero ? 26'd0 : {1'b1, b.fields.mantissa, 2'b00};
        end

        shamt      = hi_exp - lo_exp;
        lo_aligned = (shamt > 8'd25) ? 26'd0 : (lo_sig >> shamt);  // bits past the guards are lost
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            s1_sign     <= hi_sign;
            s1_eff_sub  <= a.fields.sign ^ b_sign;
            s1_neg_zero <= a_zero && b_zero && a.fields.sign && b_sign;
            s1_exp      <= hi_exp;
            s1_hi_sig   <= hi_sig;
            s1_lo_sig   <= lo_aligned;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage two: add, normalize, truncate
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        if (s1_eff_sub)
            sum = {1'b0, s1_hi_sig} - {1'b0, s1_lo_sig};  // never negative, hi is the larger
        else
            sum = {1'b0, s1_hi_sig} + {1'b0, s1_lo_sig};

        lz       = count_lz(sum[25:0]);
        norm_sig = sum[25:0] << lz;

        res.fields.sign = s1_sign;
        if (sum[26]) begin
            exp_n                = $signed({2'b00, s1_exp}) + 10'sd1;
            res.fields.mantissa  = sum[25:3];
        end else begin
            exp_n                = $signed({2'b00, s1_exp}) - $signed({5'd0, lz});
            res.fields.mantissa  = norm_sig[24:2];
        end
        res.fields.exponent = exp_n[7:0];

        // zero results are +0 unless both inputs were -0
        if (sum == 27'd0)
            res.raw = {s1_neg_zero, 31'd0};
        else if (exp_n >= 10'sd255)
            res.raw = {s1_sign, 8'hff, 23'd0};
        else if (exp_n <= 10'sd0)
            res.raw = 32'd0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            y <= '0;
        else if (enable)
            y <= res;
    end

endmodule

//--- logic/fp_addmul.sv
`timescale 1ns/1ps

module fp_addmul (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    output logic              in_ready,
    input  fpu_pkg::fpu_req_t in,
    output logic              out_valid,
    input  logic              out_ready,
    output fpu_pkg::fpu_rsp_t out
);

    logic                                stall;
    logic                                enable;
    fpu_pkg::fpu_ctrl_t                  ctrl_in;
    fpu_pkg::fpu_ctrl_t                  ctrl_q;
    fpu_pkg::fp32_t [fpu_pkg::lanes-1:0] add_y;
    fpu_pkg::fp32_t [fpu_pkg::lanes-1:0] mul_y;
    fpu_pkg::fp32_t [fpu_pkg::lanes-1:0] result;
    logic [1:0]                          inflight_q;

    assign stall    = out_valid && !out_ready;  // a held output freezes the whole pipe
    assign enable   = !stall;
    assign in_ready = enable;

    assign ctrl_in = '{tag: in.tag, op: in.op};

    // both units run on every lane, the delayed op picks one
    for (genvar i = 0; i < fpu_pkg::lanes; i++) begin : g_lane
        fp_adder i_add (
            .clk    (clk),
            .rst_n  (rst_n),
            .enable (enable),
            .sub    (in.op == fpu_pkg::op_sub),
            .a      (in.dataa[i]),
            .b      (in.datab[i]),
            .y      (add_y[i])
        );

        fp_multiplier i_mul (
            .clk    (clk),
            .rst_n  (rst_n),
            .enable (enable),
            .a      (in.dataa[i]),
            .b      (in.datab[i]),
            .y      (mul_y[i])
        );

        assign result[i] = (ctrl_q.op == fpu_pkg::op_mul) ? mul_y[i] : add_y[i];
    end

    pipe_shift_reg #(
        .depth (fpu_pkg::addmul_latency),
        .t     (fpu_pkg::fpu_ctrl_t)
    ) i_ctrl_pipe (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .in_valid  (in_valid),
        .in        (ctrl_in),
        .out_valid (out_valid),
        .out       (ctrl_q)
    );

    assign out = '{tag: ctrl_q.tag, result: result};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n)
            inflight_q <= 2'd0;
        else
            inflight_q <= inflight_q + {1'b0, in_valid && in_ready}
                                     - {1'b0, out_valid && out_ready};
    end

    a_no_phantom_output: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |-> inflight_q != 2'd0
    );

    a_stall_freezes: assert property (
        @(posedge clk) disable iff (!rst_n) stall |=> (out_valid && $stable(out))
    );

endmodule

//--- logic/fp_multiplier.sv
`timescale 1ns/1ps

module fp_multiplier (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           enable,
    input  fpu_pkg::fp32_t a,
    input  fpu_pkg::fp32_t b,
    output fpu_pkg::fp32_t y
);

    logic        s1_sign;
    logic        s1_zero;
    logic        s1_neg_zero;
    logic [8:0]  s1_exp_sum;   // biased sum, bias removed in stage two
    logic [47:0] s1_prod;

    logic signed [10:0] exp_n;
    fpu_pkg::fp32_t     res;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage one: sign, exponent sum, full product
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (enable) begin
            s1_sign     <= a.fields.sign ^ b.fields.sign;
            s1_exp_sum  <= {1'b0, a.fields.exponent} + {1'b0, b.fields.exponent};
            s1_prod     <= {1'b1, a.fields.mantissa} * {1'b1, b.fields.mantissa};
            s1_zero     <= (a.fields.exponent == 8'd0) || (b.fields.exponent == 8'd0);
            s1_neg_zero <= (a.fields.exponent == 8'd0) && (b.fields.exponent == 8'd0)
                           && a.fields.sign && b.fields.sign;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage two: normalize and range check
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        // product of two 1.x values lies in [1, 4), so at most one bit of shift
        exp_n = $signed({2'b00, s1_exp_sum}) - 11'sd127 + $signed({10'd0, s1_prod[47]});

        res.fields.sign     = s1_sign;
        res.fields.exponent = exp_n[7:0];
        if (s1_prod[47])
            res.fields.mantissa = s1_prod[46:24];
        else
            res.fields.mantissa = s1_prod[45:23];

        if (s1_zero)
            res.raw = {s1_neg_zero, 31'd0};
        else if (exp_n >= 11'sd255)
            res.raw = {s1_sign, 8'hff, 23'd0};
        else if (exp_n <= 11'sd0)
            res.raw = 32'd0;  // underflow flushes to +0
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            y <= '0;
        else if (enable)
            y <= res;
    end

endmodule

//--- logic/fpu_pkg.sv
package fpu_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // unit dimensions
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int lanes          = 4;
    localparam int tag_w          = 4;
    localparam int addmul_latency = 2;  // register stages in each lane datapath

    typedef enum logic [1:0] {
        op_add = 2'd0,
        op_sub = 2'd1,
        op_mul = 2'd2
    } fp_op_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // float word
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] mantissa;
    } fp32_fields_t;

    // the arithmetic blocks look at fields, everything else just moves raw words
    typedef union packed {
        logic [31:0]  raw;
        fp32_fields_t fields;
    } fp32_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // channel payloads
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [tag_w-1:0]  tag;
        fp_op_t            op;
        fp32_t [lanes-1:0] dataa;
        fp32_t [lanes-1:0] datab;
    } fpu_req_t;

    typedef struct packed {
        logic [tag_w-1:0]  tag;
        fp32_t [lanes-1:0] result;
    } fpu_rsp_t;

    // rides along the datapath so the result mux knows what it is looking at
    typedef struct packed {
        logic [tag_w-1:0] tag;
        fp_op_t           op;
    } fpu_ctrl_t;

endpackage

//--- logic/fpu_top.sv
`timescale 1ns/1ps

module fpu_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    output logic              req_ready,
    input  fpu_pkg::fpu_req_t req,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output fpu_pkg::fpu_rsp_t rsp
);

    logic              am_valid;
    logic              am_ready;
    fpu_pkg::fpu_rsp_t am_rsp;

    fp_addmul i_addmul (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in        (req),
        .out_valid (am_valid),
        .out_ready (am_ready),
        .out       (am_rsp)
    );

    rsp_skid_buffer i_skid (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (am_valid),
        .in_ready  (am_ready),
        .in        (am_rsp),
        .out_valid (rsp_valid),
        .out_ready (rsp_ready),
        .out       (rsp)
    );

endmodule

//--- logic/pipe_shift_reg.sv
`timescale 1ns/1ps

module pipe_shift_reg #(
    parameter int  depth = 2,
    parameter type t     = logic
) (
    input  logic clk,
    input  logic rst_n,
    input  logic enable,
    input  logic in_valid,
    input  t     in,
    output logic out_valid,
    output t     out
);

    logic [depth-1:0] valid_q;
    t                 data_q [depth];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (enable) begin
            valid_q[0] <= in_valid;
            for (int i = 1; i < depth; i++)
                valid_q[i] <= valid_q[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            data_q[0] <= in;
            for (int i = 1; i < depth; i++)
                data_q[i] <= data_q[i-1];
        end
    end

    assign out_valid = valid_q[depth-1];
    assign out       = data_q[depth-1];

endmodule

//--- logic/rsp_skid_buffer.sv
`timescale 1ns/1ps

module rsp_skid_buffer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    output logic              in_ready,
    input  fpu_pkg::fpu_rsp_t in,
    output logic              out_valid,
    input  logic              out_ready,
    output fpu_pkg::fpu_rsp_t out
);

    fpu_pkg::fpu_rsp_t entry_q [2];
    logic              wr_ptr_q;
    logic              rd_ptr_q;
    logic [1:0]        count_q;
    logic              push;
    logic              pop;

    // both flags decode the count register only, so rsp_ready never reaches req_ready
    assign in_ready  = (count_q != 2'd2);
    assign out_valid = (count_q != 2'd0);
    assign out       = entry_q[rd_ptr_q];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (push)
                wr_ptr_q <= !wr_ptr_q;
            if (pop)
                rd_ptr_q <= !rd_ptr_q;
            count_q <= count_q + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            entry_q[wr_ptr_q] <= in;
    end

    a_out_stable: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid && !out_ready |=> out_valid && $stable(out)
    );

    a_count_range: assert property (@(posedge clk) disable iff (!rst_n) count_q <= 2'd2);

endmodule

//--- verification/fpu_patterns.hex
// op tag | dataa lanes 0..3 | datab lanes 0..3 | expected result lanes 0..3
// op: 0 add, 1 sub, 2 mul
0 0 3f800000 3f800000 3fc00000 42c80000 3f800000 40000000 40200000 3e800000 40000000 40400000 40800000 42c88000
0 1 3f800000 40400000 c0000000 80000000 bf800000 bf800000 c0400000 80000000 00000000 40000000 c0a00000 80000000
0 2 00400000 40000000 00000000 80000001 3f800000 00000001 c0800000 00000001 3f800000 40000000 c0800000 00000000
0 3 3f800000 3f800000 3f800001 3fffffff 33800000 34000000 3f800001 3f800000 3f800000 3f800001 40000001 403fffff
0 4 41200000 c1000000 3f000000 41800000 c0200000 40400000 3e800000 c1800000 40f00000 c0a00000 3f400000 00000000
0 5 7f7fffff ff000000 00800000 00c00000 7f7fffff ff000000 80800000 80800000 7f800000 ff800000 00000000 00000000
0 6 3f800000 40600000 3fa00000 40c00000 00000000 3f000000 3fa00000 c0e00000 3f800000 40800000 40200000 bf800000
1 7 40400000 3f800000 40200000 bf800000 3f800000 40400000 40200000 bf800000 40000000 c0000000 00000000 00000000
1 8 3f800000 c0000000 3f000000 80000000 bf800000 40400000 3f400000 00000000 40000000 c0a00000 be800000 80000000
1 9 3f800000 3f800000 42c80000 00000000 33800000 33000000 3e800000 40a00000 3f7fffff 3f7fffff 42c78000 c0a00000
1 a 41000000 3f000000 00000001 3f800000 3f000000 41000000 3f800000 00000001 40f00000 c0f00000 bf800000 3f800000
1 b 7f7fffff 40800000 c0400000 41400000 ff7fffff 40800000 c0800000 41800000 7f800000 00000000 3f800000 c0800000
1 c 40000000 3fc00000 bf800000 41200000 3f800000 3f000000 3f800000 42c80000 3f800000 3f800000 c0000000 c2b40000
2 d 40000000 3fc00000 c0000000 bf000000 40400000 3fc00000 40400000 c0800000 40c00000 40100000 c0c00000 40000000
2 e 7f000000 ff000000 7f7fffff 5f800000 40000000 40000000 3f800000 5f800000 7f800000 ff800000 7f7fffff 7f800000
2 f 00800000 1f800000 00000000 c0400000 3f000000 1f800000 40a00000 00000000 00000000 00000000 00000000 00000000
2 0 80000000 00800000 00400000 00800000 3f800000 40000000 40000000 3f800000 00000000 01000000 00000000 00800000
2 1 3f800001 3fffffff 3fc00000 40400000 3f800001 3fffffff 3fc00001 3eaaaaab 3f800002 407ffffe 40100000 3f800000
2 2 41200000 3f000000 41400000 40e00000 41200000 3f000000 be800000 40e00000 42c80000 3e800000 c0400000 42440000
2 3 40400000 bf800000 3fa00000 40200000 40800000 bf800000 c1000000 40200000 41400000 3f800000 c1200000 40c80000

//--- verification/tb_fpu_top.sv
`timescale 1ns/1ps

module tb_fpu_top;

    localparam int n_vec          = 20;
    localparam int vec_words      = 14;  // op, tag, 4 x dataa, 4 x datab, 4 x expected
    localparam int timeout_cycles = 100;

    logic              clk;
    logic              rst_n;
    logic              req_valid;
    logic              req_ready;
    fpu_pkg::fpu_req_t req;
    logic              rsp_valid;
    logic              rsp_ready;
    fpu_pkg::fpu_rsp_t rsp;

    logic [31:0]       pattern_mem [0:n_vec*vec_words-1];
    fpu_pkg::fpu_rsp_t expected_q [$];
    fpu_pkg::fpu_rsp_t held_rsp;
    logic              hold_pending;
    logic              random_ready;
    logic [31:0]       lcg_state;
    int                cycle_count = 0;
    int                accept_edge;
    int                error_count;
    int                pass_count;
    int                fail_count;

    fpu_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pattern decoding and stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic fpu_pkg::fpu_req_t build_req(input int idx);
        fpu_pkg::fpu_req_t r;
        int                base;
        base  = idx * vec_words;
        r.op  = fpu_pkg::fp_op_t'(pattern_mem[base][1:0]);
        r.tag = pattern_mem[base+1][fpu_pkg::tag_w-1:0];
        for (int i = 0; i < fpu_pkg::lanes; i++) begin
            r.dataa[i].raw = pattern_mem[base+2+i];
            r.datab[i].raw = pattern_mem[base+6+i];
        end
        return r;
    endfunction

    function automatic fpu_pkg::fpu_rsp_t build_expected(input int idx);
        fpu_pkg::fpu_rsp_t r;
        int                base;
        base  = idx * vec_words;
        r.tag = pattern_mem[base+1][fpu_pkg::tag_w-1:0];
        for (int i = 0; i < fpu_pkg::lanes; i++)
            r.result[i].raw = pattern_mem[base+10+i];
        return r;
    endfunction

    // every step lands 10 ns after the rising edge
    task automatic next_cycle();
        logic [31:0] rnd;
        @(posedge clk);
        #10;
        if (random_ready) begin
            rnd       = lcg_next();
            rsp_ready = rnd[16];
        end
    endtask

    task automatic send_vector(input int idx);
        int waited;
        waited    = 0;
        req       = build_req(idx);
        req_valid = 1'b1;
        @(negedge clk);
        while (!req_ready && waited < timeout_cycles) begin
            next_cycle();
            @(negedge clk);
            waited++;
        end
        if (req_ready) begin
            expected_q.push_back(build_expected(idx));
            accept_edge = cycle_count + 1;  // taken on the coming rising edge
        end else begin
            $display("request %0d was never accepted, gave up at %0t", idx, $time);
            error_count++;
        end
        next_cycle();
        req_valid = 1'b0;
    endtask

    task automatic drain_responses();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < timeout_cycles) begin
            next_cycle();
            waited++;
        end
        if (expected_q.size() != 0) begin
            $display("%0d responses never arrived, gave up at %0t", expected_q.size(), $time);
            error_count++;
            expected_q.delete();
        end
    endtask

    task automatic run_group(input int first, input int last, input bit with_gaps);
        logic [31:0] rnd;
        for (int idx = first; idx <= last; idx++) begin
            if (with_gaps) begin
                rnd = lcg_next();
                repeat (rnd[17:16]) next_cycle();
            end
            send_vector(idx);
        end
        drain_responses();
    endtask

    task automatic close_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            pass_count++;
            $display("test %-14s ok", name);
        end else begin
            fail_count++;
            $display("test %-14s failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // response monitor, samples mid-cycle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_response(input fpu_pkg::fpu_rsp_t got);
        fpu_pkg::fpu_rsp_t want;
        if (expected_q.size() == 0) begin
            $display("response with tag %0h came with no request outstanding at %0t",
                     got.tag, $time);
            error_count++;
        end else begin
            want = expected_q.pop_front();
            if (got.tag !== want.tag) begin
                $display("MISMATCH at %0t: tag expected %0h got %0h", $time, want.tag, got.tag);
                error_count++;
            end
            for (int i = 0; i < fpu_pkg::lanes; i++) begin
                if (got.result[i].raw !== want.result[i].raw) begin
                    $display("MISMATCH at %0t: tag %0h lane %0d expected %08h got %08h",
                             $time, want.tag, i, want.result[i].raw, got.result[i].raw);
                    error_count++;
                end
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst_n) begin
            hold_pending = 1'b0;
        end else begin
            if (hold_pending && (rsp_valid !== 1'b1 || rsp !== held_rsp)) begin
                $display("MISMATCH at %0t: rsp changed while rsp_ready held it", $time);
                error_count++;
            end
            if (rsp_valid === 1'b1 && rsp_ready)
                check_response(rsp);  // handshake completes on the next rising edge
            hold_pending = (rsp_valid === 1'b1) && !rsp_ready;
            held_rsp     = rsp;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int errors_before;
        int waited;
        int seen_edge;
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        rsp_ready    = 1'b1;
        random_ready = 1'b0;
        lcg_state    = 32'ha284;
        error_count  = 0;
        pass_count   = 0;
        fail_count   = 0;

        $readmemh("verification/fpu_patterns.hex", pattern_mem);
        if (^pattern_mem[n_vec*vec_words-1] === 1'bx) begin
            $display("pattern file is missing or shorter than %0d vectors", n_vec);
            error_count++;
        end

        errors_before = error_count;
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            #10;
            if (rsp_valid !== 1'b0) begin
                $display("MISMATCH at %0t: rsp_valid is %b during reset", $time, rsp_valid);
                error_count++;
            end
        end
        rst_n = 1'b1;
        @(negedge clk);
        if (req_ready !== 1'b1 || rsp_valid !== 1'b0) begin
            $display("MISMATCH at %0t: after reset req_ready %b rsp_valid %b",
                     $time, req_ready, rsp_valid);
            error_count++;
        end
        next_cycle();
        close_test("reset_state", errors_before);

        errors_before = error_count;
        run_group(0, 6, 1'b0);
        close_test("add", errors_before);

        errors_before = error_count;
        run_group(7, 12, 1'b0);
        close_test("subtract", errors_before);

        errors_before = error_count;
        run_group(13, 19, 1'b0);
        close_test("multiply", errors_before);

        errors_before = error_count;
        random_ready  = 1'b1;
        run_group(0, n_vec - 1, 1'b1);
        random_ready  = 1'b0;
        rsp_ready     = 1'b1;
        repeat (4) next_cycle();
        close_test("back_pressure", errors_before);

        // one lone request, the response must be taken on the third edge after it
        errors_before = error_count;
        send_vector(0);
        waited = 0;
        @(negedge clk);
        while (rsp_valid !== 1'b1 && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
        end
        seen_edge = cycle_count + 1;
        if (rsp_valid !== 1'b1) begin
            $display("rsp_valid never rose for the lone request, gave up at %0t", $time);
            error_count++;
        end else if (seen_edge - accept_edge != 3) begin
            $display("MISMATCH at %0t: latency expected 3 got %0d", $time, seen_edge - accept_edge);
            error_count++;
        end
        next_cycle();
        drain_responses();
        close_test("latency", errors_before);

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
logic/fpu_pkg.sv
logic/fp_adder.sv
logic/fp_multiplier.sv
logic/pipe_shift_reg.sv
logic/fp_addmul.sv
logic/rsp_skid_buffer.sv
logic/fpu_top.sv
verification/tb_fpu_top.sv
